/* tag_store.f */
source/tag_store_pkg.sv
source/tag_way_ram.sv
source/tag_compare.sv
source/victim_select.sv
source/resp_reg.sv
source/tag_store_ctrl.sv
source/tag_store_top.sv
dv/tag_store_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the tag store testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tag_store_tb \
  -f tag_store.f -o tag_store_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit $build_status
fi

./obj_dir/tag_store_sim
run_status=$?
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit $run_status
fi

echo "Simulation exited cleanly"
exit 0

/* dv/tag_store_tb.sv */
`timescale 1ns/1ns

module tag_store_tb import tag_store_pkg::*; ();

  // One request and the response predicted for it
  typedef struct packed {
    mode_e    mode;
    index_t   index;
    tag_t     tag;
    logic     dirty;
    way_ind_t way;
    way_ind_t exp_way;
    logic     exp_hit;
    logic     exp_evict;
    tag_t     exp_tag;
  } row_t;

  logic     clk_i   = 1'b0;
  logic     rst_n_i = 1'b0;
  logic     valid_i = 1'b0;
  logic     ready_o;
  mode_e    mode_i  = MODE_LOOKUP;
  index_t   index_i = '0;
  tag_t     tag_i   = '0;
  logic     dirty_i = 1'b0;
  way_ind_t way_i   = '0;
  logic     valid_o;
  logic     ready_i = 1'b0;
  way_ind_t res_way_o;
  logic     res_hit_o;
  logic     res_evict_o;
  tag_t     res_evict_tag_o;

  row_t        rows [32];
  int          num_rows = 0;
  int          rx_count = 0;
  int          wait_limit = 200;
  logic [15:0] lfsr_q = 16'd53659;

  // Reference copy of the tag arrays and the round-robin pointer
  logic m_valid [NumWays][NumLines];
  logic m_dirty [NumWays][NumLines];
  tag_t m_tag   [NumWays][NumLines];
  int   m_ptr = 0;

  tag_store_top i_dut (.*);

  always #4 clk_i = ~clk_i;

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_way(input string name, input way_ind_t exp, input way_ind_t act);
    if (act !== exp) begin
      $display("ERR time %0t %s expected %b actual %b", $time, name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_tag(input string name, input tag_t exp, input tag_t act);
    if (act !== exp) begin
      $display("ERR time %0t %s expected %h actual %h", $time, name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR time %0t %s expected %b actual %b", $time, name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  // Predict the response of one request and update the model
  task automatic predict_row(inout row_t r);
    int idx;
    int hit_w;
    int vic;
    idx   = int'(r.index);
    hit_w = -1;
    vic   = -1;
    for (int w = 0; w < NumWays; w++) begin
      if (m_valid[w][idx] && m_tag[w][idx] == r.tag) hit_w = w;
    end
    if (r.mode == MODE_FLUSH) begin
      for (int w = 0; w < NumWays; w++) begin
        if (r.way[w]) vic = w;
      end
      r.exp_hit = 1'b0;
    end else if (hit_w >= 0) begin
      vic       = hit_w;
      r.exp_hit = 1'b1;
    end else begin
      // Lowest invalid way first, pointer only for a full set
      for (int w = 0; w < NumWays; w++) begin
        if (!m_valid[w][idx] && vic < 0) vic = w;
      end
      if (vic < 0) begin
        vic   = m_ptr;
        m_ptr = (m_ptr + 1) % NumWays;
      end
      r.exp_hit = 1'b0;
    end
    r.exp_way   = way_ind_t'(1) << vic;
    r.exp_evict = !r.exp_hit && m_valid[vic][idx] && m_dirty[vic][idx];
    r.exp_tag   = r.exp_hit ? '0 : m_tag[vic][idx];
    if (r.mode == MODE_FLUSH) begin
      m_valid[vic][idx] = 1'b0;
      m_dirty[vic][idx] = 1'b0;
      m_tag[vic][idx]   = '0;
    end else if (r.exp_hit) begin
      if (r.dirty) m_dirty[vic][idx] = 1'b1;
    end else begin
      m_valid[vic][idx] = 1'b1;
      m_dirty[vic][idx] = r.dirty;
      m_tag[vic][idx]   = r.tag;
    end
  endtask

  task automatic add_row(input mode_e mode, input index_t index, input tag_t tag,
                         input logic dirty, input way_ind_t way);
    row_t r;
    r       = '0;
    r.mode  = mode;
    r.index = index;
    r.tag   = tag;
    r.dirty = dirty;
    r.way   = way;
    predict_row(r);
    rows[num_rows] = r;
    num_rows++;
  endtask

  // Random back-pressure, one LFSR step per ready bit
  always @(posedge clk_i) begin
    lfsr_q = lfsr_step(lfsr_q);
    ready_i <= lfsr_q[0];
  end

  // Responses are checked in request order at the transfer
  always @(negedge clk_i) begin
    if (rst_n_i && valid_o && ready_i) begin
      if (rx_count >= num_rows) begin
        report_failure("response received with no request outstanding");
      end else begin
        check_way("res_way_o", rows[rx_count].exp_way, res_way_o);
        check_flag("res_hit_o", rows[rx_count].exp_hit, res_hit_o);
        check_flag("res_evict_o", rows[rx_count].exp_evict, res_evict_o);
        check_tag("res_evict_tag_o", rows[rx_count].exp_tag, res_evict_tag_o);
        rx_count++;
      end
    end
  end

  initial begin
    int cycles;
    for (int w = 0; w < NumWays; w++) begin
      for (int l = 0; l < NumLines; l++) begin
        m_valid[w][l] = 1'b0;
        m_dirty[w][l] = 1'b0;
        m_tag[w][l]   = '0;
      end
    end
    // Fill set 3, then hits, a dirty upgrade and a flush of the dirty way
    add_row(MODE_LOOKUP, 4'd3, 8'h10, 1'b0, 4'b0000);
    add_row(MODE_LOOKUP, 4'd3, 8'h11, 1'b1, 4'b0000);
    add_row(MODE_LOOKUP, 4'd3, 8'h12, 1'b0, 4'b0000);
    add_row(MODE_LOOKUP, 4'd3, 8'h13, 1'b0, 4'b0000);
    add_row(MODE_LOOKUP, 4'd3, 8'h12, 1'b0, 4'b0000);
    add_row(MODE_LOOKUP, 4'd3, 8'h10, 1'b1, 4'b0000);
    add_row(MODE_FLUSH,  4'd3, 8'h00, 1'b0, 4'b0001);
    add_row(MODE_LOOKUP, 4'd3, 8'h10, 1'b0, 4'b0000);
    // Full set replacements walk the pointer
    add_row(MODE_LOOKUP, 4'd3, 8'h30, 1'b0, 4'b0000);
    add_row(MODE_LOOKUP, 4'd3, 8'h31, 1'b0, 4'b0000);
    add_row(MODE_LOOKUP, 4'd3, 8'h31, 1'b1, 4'b0000);
    add_row(MODE_FLUSH,  4'd3, 8'h00, 1'b0, 4'b0010);
    add_row(MODE_FLUSH,  4'd3, 8'h00, 1'b0, 4'b0100);
    add_row(MODE_FLUSH,  4'd3, 8'h00, 1'b0, 4'b0100);
    // Second set, and refill of set 3 holes
    add_row(MODE_LOOKUP, 4'd9, 8'h31, 1'b1, 4'b0000);
    add_row(MODE_LOOKUP, 4'd3, 8'h44, 1'b1, 4'b0000);
    add_row(MODE_LOOKUP, 4'd9, 8'h31, 1'b0, 4'b0000);
    add_row(MODE_FLUSH,  4'd9, 8'h00, 1'b0, 4'b0001);

    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_flag("ready_o", 1'b1, ready_o);
    check_flag("valid_o", 1'b0, valid_o);

    @(posedge clk_i);
    for (int i = 0; i < num_rows; i++) begin
      valid_i <= 1'b1;
      mode_i  <= rows[i].mode;
      index_i <= rows[i].index;
      tag_i   <= rows[i].tag;
      dirty_i <= rows[i].dirty;
      way_i   <= rows[i].way;
      cycles = 0;
      @(negedge clk_i);
      while (!ready_o) begin
        cycles++;
        if (cycles > wait_limit) report_failure("ready_o stayed low, request not accepted");
        @(negedge clk_i);
      end
      // Request transfers at this edge
      @(posedge clk_i);
    end
    valid_i <= 1'b0;

    cycles = 0;
    while (rx_count < num_rows) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > wait_limit) report_failure("responses missing, valid_o never delivered them");
    end
    // Idle margin so a duplicate response is caught
    repeat (4) @(posedge clk_i);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* source/tag_store_top.sv */
`timescale 1ns/1ns

module tag_store_top import tag_store_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Request
  input  logic     valid_i,
  output logic     ready_o,
  input  mode_e    mode_i,
  input  index_t   index_i,
  input  tag_t     tag_i,
  input  logic     dirty_i,
  input  way_ind_t way_i,
  // Response
  output logic     valid_o,
  input  logic     ready_i,
  output way_ind_t res_way_o,
  output logic     res_hit_o,
  output logic     res_evict_o,
  output tag_t     res_evict_tag_o
);

  // Way array side
  logic                     rd;
  index_t                   index;
  way_ind_t                 we;
  tag_entry_t               wdata;
  tag_entry_t [NumWays-1:0] rdata;

  // Compare and victim side
  tag_t       req_tag;
  way_ind_t   sel_way;
  way_ind_t   hit;
  way_ind_t   valid_bits;
  way_ind_t   dirty_bits;
  tag_entry_t sel_entry;
  way_ind_t   victim;
  logic       victim_use;

  // Response staging
  logic     resp_full;
  logic     resp_unload;
  logic     load;
  way_ind_t ctrl_way;
  logic     ctrl_hit;
  logic     ctrl_evict;
  tag_t     ctrl_evict_tag;

  tag_store_ctrl i_ctrl (
    .clk_i, .rst_n_i, .valid_i, .ready_o, .mode_i, .index_i, .tag_i, .dirty_i, .way_i,
    .rd_o            (rd),
    .index_o         (index),
    .we_o            (we),
    .wdata_o         (wdata),
    .req_tag_o       (req_tag),
    .sel_way_o       (sel_way),
    .hit_i           (hit),
    .valid_bits_i    (valid_bits),
    .dirty_bits_i    (dirty_bits),
    .sel_entry_i     (sel_entry),
    .victim_i        (victim),
    .victim_use_o    (victim_use),
    .resp_full_i     (resp_full),
    .resp_unload_i   (resp_unload),
    .load_o          (load),
    .res_way_o       (ctrl_way),
    .res_hit_o       (ctrl_hit),
    .res_evict_o     (ctrl_evict),
    .res_evict_tag_o (ctrl_evict_tag)
  );

  // One tag array per way, all share index and read strobe
  for (genvar w = 0; w < NumWays; w++) begin : gen_way
    tag_way_ram i_ram (
      .clk_i, .rst_n_i,
      .rd_i    (rd),
      .we_i    (we[w]),
      .index_i (index),
      .wdata_i (wdata),
      .rdata_o (rdata[w])
    );
  end

  tag_compare i_compare (
    .rdata_i      (rdata),
    .req_tag_i    (req_tag),
    .sel_way_i    (sel_way),
    .hit_o        (hit),
    .valid_bits_o (valid_bits),
    .dirty_bits_o (dirty_bits),
    .sel_entry_o  (sel_entry)
  );

  victim_select i_victim (
    .clk_i, .rst_n_i,
    .valid_bits_i (valid_bits),
    .use_i        (victim_use),
    .victim_o     (victim)
  );

  resp_reg i_resp (
    .clk_i, .rst_n_i, .ready_i, .valid_o,
    .load_i      (load),
    .way_i       (ctrl_way),
    .hit_i       (ctrl_hit),
    .evict_i     (ctrl_evict),
    .evict_tag_i (ctrl_evict_tag),
    .full_o      (resp_full),
    .unload_o    (resp_unload),
    .way_o       (res_way_o),
    .hit_o       (res_hit_o),
    .evict_o     (res_evict_o),
    .evict_tag_o (res_evict_tag_o)
  );

endmodule

/* source/tag_store_ctrl.sv */
`timescale 1ns/1ns

module tag_store_ctrl import tag_store_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  // Request side
  input  logic       valid_i,
  output logic       ready_o,
  input  mode_e      mode_i,
  input  index_t     index_i,
  input  tag_t       tag_i,
  input  logic       dirty_i,
  input  way_ind_t   way_i,
  // Way array control
  output logic       rd_o,
  output index_t     index_o,
  output way_ind_t   we_o,
  output tag_entry_t wdata_o,
  // Compare results
  output tag_t       req_tag_o,
  output way_ind_t   sel_way_o,
  input  way_ind_t   hit_i,
  input  way_ind_t   valid_bits_i,
  input  way_ind_t   dirty_bits_i,
  input  tag_entry_t sel_entry_i,
  // Victim choice
  input  way_ind_t   victim_i,
  output logic       victim_use_o,
  // Output register
  input  logic       resp_full_i,
  input  logic       resp_unload_i,
  output logic       load_o,
  output way_ind_t   res_way_o,
  output logic       res_hit_o,
  output logic       res_evict_o,
  output tag_t       res_evict_tag_o
);

  ctrl_state_e state_q, state_d;

  // Captured request
  mode_e    mode_q;
  index_t   index_q;
  tag_t     tag_q;
  logic     dirty_q;
  way_ind_t way_q;

  logic accept;
  logic resp_free;
  logic lookup_hit;
  logic hit_clean;

  assign ready_o = (state_q == ST_IDLE);
  assign accept  = valid_i & ready_o;

  // Output register can take a new response this cycle
  assign resp_free = ~resp_full_i | resp_unload_i;

  assign lookup_hit = (mode_q == MODE_LOOKUP) & (|hit_i);
  // Hit entry not yet marked dirty
  assign hit_clean  = ~|(hit_i & dirty_bits_i);

  // Way the response and any write-back refer to
  assign sel_way_o = (mode_q == MODE_FLUSH) ? way_q :
                     (lookup_hit ? hit_i : victim_i);
  assign req_tag_o = tag_q;

  // Response fields, read data is stable in ST_READ and ST_WAIT
  assign res_way_o       = sel_way_o;
  assign res_hit_o       = lookup_hit;
  assign res_evict_o     = ~lookup_hit & (|(sel_way_o & valid_bits_i & dirty_bits_i));
  assign res_evict_tag_o = lookup_hit ? '0 : sel_entry_i.tag;

  always_comb begin
    state_d      = state_q;
    rd_o         = 1'b0;
    index_o      = index_q;
    we_o         = '0;
    wdata_o      = '0;
    victim_use_o = 1'b0;
    load_o       = 1'b0;
    unique case (state_q)
      ST_IDLE: begin
        if (valid_i) begin
          // Read all ways of the requested set at the accept edge
          rd_o    = 1'b1;
          index_o = index_i;
          state_d = ST_READ;
        end
      end
      ST_READ, ST_WAIT: begin
        if (resp_free) begin
          load_o  = 1'b1;
          state_d = ST_IDLE;
          if (mode_q == MODE_FLUSH) begin
            // Clear the named way
            we_o = sel_way_o;
          end else if (lookup_hit) begin
            // Only upgrade a clean line to dirty
            if (dirty_q && hit_clean) begin
              we_o    = sel_way_o;
              wdata_o = '{valid: 1'b1, dirty: 1'b1, tag: tag_q};
            end
          end else begin
            // Miss, allocate the victim
            we_o         = sel_way_o;
            wdata_o      = '{valid: 1'b1, dirty: dirty_q, tag: tag_q};
            victim_use_o = 1'b1;
          end
        end else begin
          state_d = ST_WAIT;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mode_q  <= mode_i;
      index_q <= index_i;
      tag_q   <= tag_i;
      dirty_q <= dirty_i;
      way_q   <= way_i;
    end
  end

  // A flush names exactly one way
  a_flush_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (accept && mode_i == MODE_FLUSH) |-> $onehot(way_i))
    else $error("flush accepted without a one-hot way");

endmodule

/* source/resp_reg.sv */
`timescale 1ns/1ns

module resp_reg import tag_store_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     load_i,
  input  way_ind_t way_i,
  input  logic     hit_i,
  input  logic     evict_i,
  input  tag_t     evict_tag_i,
  input  logic     ready_i,
  output logic     full_o,
  output logic     unload_o,
  output logic     valid_o,
  output way_ind_t way_o,
  output logic     hit_o,
  output logic     evict_o,
  output tag_t     evict_tag_o
);

  logic full_q;

  assign full_o   = full_q;
  assign valid_o  = full_q;
  assign unload_o = full_q & ready_i;

  // Load wins over a same-edge unload
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (load_i) begin
      full_q <= 1'b1;
    end else if (unload_o) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      way_o       <= way_i;
      hit_o       <= hit_i;
      evict_o     <= evict_i;
      evict_tag_o <= evict_tag_i;
    end
  end

  // Stalled response holds valid and data
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && !ready_i) |=> valid_o && $stable({way_o, hit_o, evict_o, evict_tag_o}))
    else $error("response changed while stalled");

endmodule

/* source/victim_select.sv */
`timescale 1ns/1ns

module victim_select import tag_store_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  way_ind_t valid_bits_i,
  input  logic     use_i,
  output way_ind_t victim_o
);

  way_idx_t ptr_q;
  way_ind_t free_way;
  logic     all_valid;

  assign all_valid = &valid_bits_i;

  // Lowest-numbered invalid way, scan from the top down
  always_comb begin
    free_way = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (!valid_bits_i[w]) begin
        free_way    = '0;
        free_way[w] = 1'b1;
      end
    end
  end

  // Full set falls back to the round-robin way
  always_comb begin
    if (all_valid) begin
      victim_o        = '0;
      victim_o[ptr_q] = 1'b1;
    end else begin
      victim_o = free_way;
    end
  end

  // Pointer moves only when it was actually used for a replacement
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (use_i && all_valid) begin
      if (ptr_q == way_idx_t'(NumWays - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= ptr_q + way_idx_t'(1);
      end
    end
  end

endmodule

/* source/tag_compare.sv */
`timescale 1ns/1ns

module tag_compare import tag_store_pkg::*; (
  input  tag_entry_t [NumWays-1:0] rdata_i,
  input  tag_t                     req_tag_i,
  input  way_ind_t                 sel_way_i,
  output way_ind_t                 hit_o,
  output way_ind_t                 valid_bits_o,
  output way_ind_t                 dirty_bits_o,
  output tag_entry_t               sel_entry_o
);

  way_idx_t sel_idx;

  // Per-way match, only valid entries can hit
  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      valid_bits_o[w] = rdata_i[w].valid;
      dirty_bits_o[w] = rdata_i[w].dirty;
      hit_o[w]        = rdata_i[w].valid & (rdata_i[w].tag == req_tag_i);
    end
  end

  // One-hot to binary, selection is one-hot by construction
  always_comb begin
    sel_idx = '0;
    for (int w = 0; w < NumWays; w++) begin
      if (sel_way_i[w]) begin
        sel_idx = sel_idx | way_idx_t'(w);
      end
    end
  end

  // Stored entry of the selected way
  assign sel_entry_o = rdata_i[sel_idx];

  // A tag is allocated in at most one way of a set
  always_comb begin
    a_hit_onehot0: assert final ($onehot0(hit_o))
      else $error("multiple ways hit the same tag");
  end

endmodule

/* source/tag_way_ram.sv */
`timescale 1ns/1ns

module tag_way_ram import tag_store_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       rd_i,
  input  logic       we_i,
  input  index_t     index_i,
  input  tag_entry_t wdata_i,
  output tag_entry_t rdata_o
);

  // One entry per set
  tag_entry_t mem_q [NumLines];
  tag_entry_t rdata_q;

  // Array clears to all invalid
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NumLines; i++) begin
        mem_q[i] <= '0;
      end
    end else if (we_i) begin
      mem_q[index_i] <= wdata_i;
    end
  end

  // Registered read port, data holds until the next read
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (rd_i) begin
      rdata_q <= mem_q[index_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* source/tag_store_pkg.sv */
package tag_store_pkg;

  // Cache geometry
  localparam int unsigned NumWays     = 4;
  localparam int unsigned NumLines    = 16;
  localparam int unsigned IndexWidth  = 4;
  localparam int unsigned TagWidth    = 8;
  localparam int unsigned WayIdxWidth = 2;

  // Bit per way, used one-hot for way selection
  typedef logic [NumWays-1:0] way_ind_t;

  // Binary way number
  typedef logic [WayIdxWidth-1:0] way_idx_t;

  // Set index, the address into each way array
  typedef logic [IndexWidth-1:0] index_t;

  // Tag value
  typedef logic [TagWidth-1:0] tag_t;

  // Stored entry of one way in one set
  typedef struct packed {
    // Entry holds a line
    logic valid;
    // Line was modified since allocation
    logic dirty;
    // Tag of the held line
    tag_t tag;
  } tag_entry_t;

  // Request kinds
  typedef enum logic [0:0] {
    MODE_LOOKUP = 1'b0,
    MODE_FLUSH  = 1'b1
  } mode_e;

  // Controller states
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_READ = 2'd1,
    ST_WAIT = 2'd2
  } ctrl_state_e;

endpackage
